//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_hdr_split_join
FILELIST  ?= hdr_split_join.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axi4s_if.sv
// ------------------------------
// axi4s_if
// AXI4-Stream link between blocks
// inside the split/join design.
// ------------------------------

`timescale 1ns/1ps

interface axi4s_if;

   axi4s_pkg::tdata_t tdata;
   axi4s_pkg::tkeep_t tkeep;
   logic              tlast;
   logic              tvalid;
   logic              tready;

   // sender side.
   modport tx (
      output tdata, tkeep, tlast, tvalid,
      input  tready
   );

   // receiver side.
   modport rx (
      input  tdata, tkeep, tlast, tvalid,
      output tready
   );

endinterface

//--- axi4s_pkg.sv
// ------------------------------
// axi4s_pkg
// stream word widths and the beat
// record stored by the FIFOs.
// ------------------------------

package axi4s_pkg;

   // bytes carried by one stream word.
   localparam int data_bytes = 8;

   // data word and byte-valid mask.
   typedef logic [data_bytes*8-1:0] tdata_t;
   typedef logic [data_bytes-1:0]   tkeep_t;

   // ------------------------------
   // one stream beat as held in a FIFO.
   // ------------------------------
   typedef struct packed {
      tdata_t tdata;
      tkeep_t tkeep;
      logic   tlast;
   } axi4s_word_t;

endpackage

//--- hdr_join.sv
// ------------------------------
// hdr_join
// appends each stored payload to its
// processed header and flags headers
// that arrive with no split packet.
// ------------------------------

`timescale 1ns/1ps

module hdr_join (
   input  logic                      axi4s_in,
   input  logic                      rst_n,
   input  logic                      enable,
   axi4s_if.rx                       hdr_in,
   axi4s_if.tx                       pkt_out,
   output logic                      pyld_pop,
   input  axi4s_pkg::axi4s_word_t    pyld_word,
   input  logic                      pyld_empty,
   output logic                      desc_pop,
   input  split_join_pkg::pkt_desc_t desc,
   input  logic                      desc_empty,
   output logic                      sop_mismatch
);

   typedef enum logic [1:0] {
      st_header,
      st_payload,
      st_orphan
   } state_t;

   state_t                 state;
   state_t                 nxt_state;
   logic                   sop_q;
   logic                   nxt_sop;
   logic                   has_pyld_q;
   logic                   nxt_has;
   logic                   cur_has;
   logic                   out_rdy;
   logic                   beat_v;
   logic                   start_miss;
   axi4s_pkg::axi4s_word_t beat;

   assign out_rdy = !pkt_out.tvalid || pkt_out.tready;

   // ------------------------------
   // beat selection and next state.
   // ------------------------------
   always_comb begin
      hdr_in.tready = 1'b0;
      pyld_pop      = 1'b0;
      desc_pop      = 1'b0;
      beat_v        = 1'b0;
      start_miss    = 1'b0;
      beat.tdata    = hdr_in.tdata;
      beat.tkeep    = hdr_in.tkeep;
      beat.tlast    = hdr_in.tlast;
      cur_has       = sop_q ? desc.has_payload : has_pyld_q;
      nxt_state     = state;
      nxt_sop       = sop_q;
      nxt_has       = has_pyld_q;
      if (!enable) begin
         // in bypass the header stream goes straight out.
         hdr_in.tready = out_rdy;
         beat_v        = hdr_in.tvalid && out_rdy;
      end else begin
         case (state)
            st_header: begin
               hdr_in.tready = out_rdy;
               if (hdr_in.tvalid && out_rdy) begin
                  beat_v  = 1'b1;
                  nxt_sop = hdr_in.tlast;
                  if (sop_q && desc_empty) begin
                     // with no split packet waiting it passes through alone.
                     start_miss = 1'b1;
                     if (!hdr_in.tlast) begin
                        nxt_state = st_orphan;
                     end
                  end else begin
                     desc_pop = sop_q;
                     nxt_has  = cur_has;
                     if (hdr_in.tlast && cur_has) begin
                        beat.tlast = 1'b0;
                        nxt_sop    = 1'b0;
                        nxt_state  = st_payload;
                     end
                  end
               end
            end
            st_payload: begin
               beat   = pyld_word;
               beat_v = !pyld_empty && out_rdy;
               pyld_pop = beat_v;
               if (beat_v && pyld_word.tlast) begin
                  nxt_sop   = 1'b1;
                  nxt_state = st_header;
               end
            end
            default: begin
               hdr_in.tready = out_rdy;
               beat_v        = hdr_in.tvalid && out_rdy;
               if (beat_v && hdr_in.tlast) begin
                  nxt_sop   = 1'b1;
                  nxt_state = st_header;
               end
            end
         endcase
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (!rst_n) begin
         state          <= st_header;
         sop_q          <= 1'b1;
         has_pyld_q     <= 1'b0;
         pkt_out.tvalid <= 1'b0;
         sop_mismatch   <= 1'b0;
      end else begin
         state        <= nxt_state;
         sop_q        <= nxt_sop;
         has_pyld_q   <= nxt_has;
         sop_mismatch <= start_miss;
         if (out_rdy) begin
            pkt_out.tvalid <= beat_v;
         end
      end
   end

   // output stage data.
   always_ff @(posedge axi4s_in) begin
      if (beat_v) begin
         pkt_out.tdata <= beat.tdata;
         pkt_out.tkeep <= beat.tkeep;
         pkt_out.tlast <= beat.tlast;
      end
   end

endmodule

//--- hdr_split.sv
// ------------------------------
// hdr_split
// sends the first hdr_length words of each
// packet to the header stream and queues
// the rest for the joiner.
// ------------------------------

`timescale 1ns/1ps

module hdr_split (
   input  logic                      axi4s_in,
   input  logic                      rst_n,
   input  split_join_pkg::hdr_len_t  hdr_length,
   axi4s_if.rx                       pkt_in,
   axi4s_if.tx                       hdr_out,
   output logic                      pyld_push,
   output axi4s_pkg::axi4s_word_t    pyld_word,
   input  logic                      pyld_full,
   output logic                      desc_push,
   output split_join_pkg::pkt_desc_t desc,
   input  logic                      desc_full,
   output logic                      enable
);

   split_join_pkg::hdr_len_t len_q;
   split_join_pkg::hdr_len_t cnt;
   split_join_pkg::hdr_len_t hdr_last_idx;
   logic                     in_pkt;
   logic                     hdr_rdy;
   logic                     pyld_rdy;
   logic                     desc_rdy;
   logic                     xfer;
   logic                     to_hdr;
   logic                     hdr_end;
   logic                     desc_now;

   // each output stage frees up when empty or when its sink takes it.
   assign hdr_rdy  = !hdr_out.tvalid || hdr_out.tready;
   assign pyld_rdy = !pyld_push || !pyld_full;
   assign desc_rdy = !desc_push || !desc_full;

   assign pkt_in.tready = hdr_rdy && pyld_rdy && desc_rdy;
   assign xfer          = pkt_in.tvalid && pkt_in.tready;

   // word routing.
   assign hdr_last_idx = len_q - 8'd1;
   assign to_hdr       = !enable || (cnt < len_q);
   assign hdr_end      = pkt_in.tlast || (enable && (cnt == hdr_last_idx));

   // the descriptor goes out as soon as the header ends, so a fast
   // header processor never finds the descriptor FIFO empty.
   assign desc_now = enable && to_hdr && hdr_end;

   always_ff @(posedge axi4s_in) begin
      if (!rst_n) begin
         len_q          <= '0;
         enable         <= 1'b0;
         cnt            <= '0;
         in_pkt         <= 1'b0;
         hdr_out.tvalid <= 1'b0;
         pyld_push      <= 1'b0;
         desc_push      <= 1'b0;
      end else begin
         // length only changes between packets.
         if (!in_pkt && !xfer) begin
            len_q  <= hdr_length;
            enable <= (hdr_length != '0);
         end
         if (xfer) begin
            in_pkt <= !pkt_in.tlast;
            if (pkt_in.tlast) begin
               cnt <= '0;
            end else if (enable && (cnt < len_q)) begin
               cnt <= cnt + 8'd1;
            end
         end
         if (hdr_rdy) begin
            hdr_out.tvalid <= xfer && to_hdr;
         end
         if (pyld_rdy) begin
            pyld_push <= xfer && !to_hdr;
         end
         if (desc_rdy) begin
            desc_push <= xfer && desc_now;
         end
      end
   end

   // ------------------------------
   // output payload registers.
   // ------------------------------
   always_ff @(posedge axi4s_in) begin
      if (xfer && to_hdr) begin
         hdr_out.tdata <= pkt_in.tdata;
         hdr_out.tkeep <= pkt_in.tkeep;
         hdr_out.tlast <= hdr_end;
      end
      if (xfer && !to_hdr) begin
         pyld_word.tdata <= pkt_in.tdata;
         pyld_word.tkeep <= pkt_in.tkeep;
         pyld_word.tlast <= pkt_in.tlast;
      end
      if (xfer && desc_now) begin
         desc.has_payload <= !pkt_in.tlast;
      end
   end

endmodule

//--- hdr_split_join.f
axi4s_pkg.sv
split_join_pkg.sv
axi4s_if.sv
sync_fifo.sv
hdr_split.sv
hdr_join.sv
hdr_split_join.sv
tb_hdr_split_join.sv

//--- hdr_split_join.sv
// ------------------------------
// hdr_split_join
// header split and join for in-line
// header processing. Payload waits in
// a FIFO while the header is processed.
// ------------------------------

`timescale 1ns/1ps

module hdr_split_join (
   input  logic                     axi4s_in,
   input  logic                     rst_n,
   input  split_join_pkg::hdr_len_t hdr_length,
   input  axi4s_pkg::tdata_t        in_tdata,
   input  axi4s_pkg::tkeep_t        in_tkeep,
   input  logic                     in_tlast,
   input  logic                     in_tvalid,
   output logic                     in_tready,
   output axi4s_pkg::tdata_t        out_tdata,
   output axi4s_pkg::tkeep_t        out_tkeep,
   output logic                     out_tlast,
   output logic                     out_tvalid,
   input  logic                     out_tready,
   output axi4s_pkg::tdata_t        hdr_out_tdata,
   output axi4s_pkg::tkeep_t        hdr_out_tkeep,
   output logic                     hdr_out_tlast,
   output logic                     hdr_out_tvalid,
   input  logic                     hdr_out_tready,
   input  axi4s_pkg::tdata_t        hdr_in_tdata,
   input  axi4s_pkg::tkeep_t        hdr_in_tkeep,
   input  logic                     hdr_in_tlast,
   input  logic                     hdr_in_tvalid,
   output logic                     hdr_in_tready,
   output logic                     sop_mismatch
);

   axi4s_if in_if ();
   axi4s_if out_if ();
   axi4s_if hdr_out_if ();
   axi4s_if hdr_in_if ();

   logic                      enable;
   logic                      pyld_push;
   logic                      pyld_full;
   logic                      pyld_pop;
   logic                      pyld_empty;
   axi4s_pkg::axi4s_word_t    pyld_wr;
   axi4s_pkg::axi4s_word_t    pyld_rd;
   logic                      desc_push;
   logic                      desc_full;
   logic                      desc_pop;
   logic                      desc_empty;
   split_join_pkg::pkt_desc_t desc_wr;
   split_join_pkg::pkt_desc_t desc_rd;

   // ------------------------------
   // top-level ports onto the links.
   // ------------------------------
   assign in_if.tdata      = in_tdata;
   assign in_if.tkeep      = in_tkeep;
   assign in_if.tlast      = in_tlast;
   assign in_if.tvalid     = in_tvalid;
   assign in_tready        = in_if.tready;
   assign out_tdata        = out_if.tdata;
   assign out_tkeep        = out_if.tkeep;
   assign out_tlast        = out_if.tlast;
   assign out_tvalid       = out_if.tvalid;
   assign out_if.tready    = out_tready;
   assign hdr_out_tdata    = hdr_out_if.tdata;
   assign hdr_out_tkeep    = hdr_out_if.tkeep;
   assign hdr_out_tlast    = hdr_out_if.tlast;
   assign hdr_out_tvalid   = hdr_out_if.tvalid;
   assign hdr_out_if.tready = hdr_out_tready;
   assign hdr_in_if.tdata  = hdr_in_tdata;
   assign hdr_in_if.tkeep  = hdr_in_tkeep;
   assign hdr_in_if.tlast  = hdr_in_tlast;
   assign hdr_in_if.tvalid = hdr_in_tvalid;
   assign hdr_in_tready    = hdr_in_if.tready;

   hdr_split i_split (
      .axi4s_in   (axi4s_in),
      .rst_n      (rst_n),
      .hdr_length (hdr_length),
      .pkt_in     (in_if),
      .hdr_out    (hdr_out_if),
      .pyld_push  (pyld_push),
      .pyld_word  (pyld_wr),
      .pyld_full  (pyld_full),
      .desc_push  (desc_push),
      .desc       (desc_wr),
      .desc_full  (desc_full),
      .enable     (enable)
   );

   // payload words.
   sync_fifo #(
      .entry_t (axi4s_pkg::axi4s_word_t),
      .depth   (split_join_pkg::pyld_fifo_depth)
   ) i_pyld_fifo (
      .axi4s_in (axi4s_in),
      .rst_n    (rst_n),
      .push     (pyld_push),
      .wr_data  (pyld_wr),
      .full     (pyld_full),
      .pop      (pyld_pop),
      .rd_data  (pyld_rd),
      .empty    (pyld_empty)
   );

   // one descriptor per split packet.
   sync_fifo #(
      .entry_t (split_join_pkg::pkt_desc_t),
      .depth   (split_join_pkg::desc_fifo_depth)
   ) i_desc_fifo (
      .axi4s_in (axi4s_in),
      .rst_n    (rst_n),
      .push     (desc_push),
      .wr_data  (desc_wr),
      .full     (desc_full),
      .pop      (desc_pop),
      .rd_data  (desc_rd),
      .empty    (desc_empty)
   );

   hdr_join i_join (
      .axi4s_in     (axi4s_in),
      .rst_n        (rst_n),
      .enable       (enable),
      .hdr_in       (hdr_in_if),
      .pkt_out      (out_if),
      .pyld_pop     (pyld_pop),
      .pyld_word    (pyld_rd),
      .pyld_empty   (pyld_empty),
      .desc_pop     (desc_pop),
      .desc         (desc_rd),
      .desc_empty   (desc_empty),
      .sop_mismatch (sop_mismatch)
   );

endmodule

//--- split_join_pkg.sv
// ------------------------------
// split_join_pkg
// sizing of the split/join buffers
// and the per-packet descriptor.
// ------------------------------

package split_join_pkg;

   // header length, counted in whole stream words.
   typedef logic [7:0] hdr_len_t;

   // ------------------------------
   // buffer depths.
   // ------------------------------
   // payload words waiting for their header.
   localparam int pyld_fifo_depth = 64;

   // split packets waiting for their header to return.
   localparam int desc_fifo_depth = 16;

   // ------------------------------
   // descriptor written once per split packet.
   // ------------------------------
   // has_payload is set when words beyond the header were queued.
   typedef struct packed {
      logic has_payload;
   } pkt_desc_t;

endpackage

//--- sync_fifo.sv
// ------------------------------
// sync_fifo
// single-clock first-word-fall-through
// FIFO, entry type set by parameter.
// ------------------------------

`timescale 1ns/1ps

module sync_fifo #(
   parameter type entry_t = logic,
   parameter int  depth   = 16
) (
   input  logic   axi4s_in,
   input  logic   rst_n,
   input  logic   push,
   input  entry_t wr_data,
   output logic   full,
   input  logic   pop,
   output entry_t rd_data,
   output logic   empty
);

   localparam int                ptr_w     = $clog2(depth);
   localparam logic [ptr_w-1:0] last_ptr  = ptr_w'(depth - 1);
   localparam logic [ptr_w:0]   max_count = (ptr_w + 1)'(depth);

   entry_t           mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             wr_en;
   logic             rd_en;

   // pushes into a full FIFO and pops from an empty one are ignored.
   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   assign full    = (count == max_count);
   assign empty   = (count == '0);
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge axi4s_in) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // ------------------------------
   // pointers and occupancy.
   // ------------------------------
   always_ff @(posedge axi4s_in) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- tb_hdr_split_join.sv
// ------------------------------
// tb_hdr_split_join
// testbench for the header split and
// join block, with a header processor
// model that loops headers back.
// ------------------------------

`timescale 1ns/1ps

module tb_hdr_split_join;

   typedef axi4s_pkg::axi4s_word_t beat_t;
   typedef beat_t beat_q_t[$];

   localparam int                beat_w     = $bits(beat_t);
   localparam int                pkt_count  = 200;
   localparam int                wait_limit = 2000;
   localparam axi4s_pkg::tdata_t hdr_key    = 64'h5a3c_96e1_0ff0_c35a;

   int seed = 49944;

   logic                     axi4s_in;
   logic                     rst_n;
   split_join_pkg::hdr_len_t hdr_length;
   axi4s_pkg::tdata_t        in_tdata;
   axi4s_pkg::tkeep_t        in_tkeep;
   logic                     in_tlast;
   logic                     in_tvalid;
   logic                     in_tready;
   axi4s_pkg::tdata_t        out_tdata;
   axi4s_pkg::tkeep_t        out_tkeep;
   logic                     out_tlast;
   logic                     out_tvalid;
   logic                     out_tready;
   axi4s_pkg::tdata_t        hdr_out_tdata;
   axi4s_pkg::tkeep_t        hdr_out_tkeep;
   logic                     hdr_out_tlast;
   logic                     hdr_out_tvalid;
   logic                     hdr_out_tready;
   axi4s_pkg::tdata_t        hdr_in_tdata;
   axi4s_pkg::tkeep_t        hdr_in_tkeep;
   logic                     hdr_in_tlast;
   logic                     hdr_in_tvalid;
   logic                     hdr_in_tready;
   logic                     sop_mismatch;

   // expected beats on out and hdr_out, and headers waiting to return.
   beat_q_t exp_out_q;
   beat_q_t exp_hdr_q;
   beat_q_t ret_q;

   int   mism_errs  = 0;
   int   other_errs = 0;
   int   out_beats  = 0;
   int   sop_pulses = 0;
   logic stall_on   = 1'b0;
   logic aborted    = 1'b0;

   hdr_split_join i_dut (
      .axi4s_in       (axi4s_in),
      .rst_n          (rst_n),
      .hdr_length     (hdr_length),
      .in_tdata       (in_tdata),
      .in_tkeep       (in_tkeep),
      .in_tlast       (in_tlast),
      .in_tvalid      (in_tvalid),
      .in_tready      (in_tready),
      .out_tdata      (out_tdata),
      .out_tkeep      (out_tkeep),
      .out_tlast      (out_tlast),
      .out_tvalid     (out_tvalid),
      .out_tready     (out_tready),
      .hdr_out_tdata  (hdr_out_tdata),
      .hdr_out_tkeep  (hdr_out_tkeep),
      .hdr_out_tlast  (hdr_out_tlast),
      .hdr_out_tvalid (hdr_out_tvalid),
      .hdr_out_tready (hdr_out_tready),
      .hdr_in_tdata   (hdr_in_tdata),
      .hdr_in_tkeep   (hdr_in_tkeep),
      .hdr_in_tlast   (hdr_in_tlast),
      .hdr_in_tvalid  (hdr_in_tvalid),
      .hdr_in_tready  (hdr_in_tready),
      .sop_mismatch   (sop_mismatch)
   );

   initial begin
      axi4s_in = 1'b0;
      forever #2 axi4s_in = ~axi4s_in;
   end

   // ------------------------------
   // reference model.
   // ------------------------------
   // rebuilt packet with header words keyed, payload kept and tlast on the final word.
   function automatic beat_q_t expected_out(input beat_q_t pkt, input int hlen);
      beat_q_t res;
      beat_t   w;
      int      i;
      for (i = 0; i < pkt.size(); i++) begin
         w = pkt[i];
         if (hlen == 0 || i < hlen) begin
            w.tdata = w.tdata ^ hdr_key;
         end
         w.tlast = (i == pkt.size() - 1);
         res.push_back(w);
      end
      return res;
   endfunction

   // header stream carries the first hlen words, or all of them in bypass.
   function automatic beat_q_t expected_hdr(input beat_q_t pkt, input int hlen);
      beat_q_t res;
      beat_t   w;
      int      i;
      int      n;
      n = (hlen == 0 || hlen > pkt.size()) ? pkt.size() : hlen;
      for (i = 0; i < n; i++) begin
         w       = pkt[i];
         w.tlast = (i == n - 1);
         res.push_back(w);
      end
      return res;
   endfunction

   task automatic check_equal(input logic [beat_w-1:0] actual,
                              input logic [beat_w-1:0] expected, input string what);
      if (actual !== expected) begin
         mism_errs++;
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, actual, expected);
      end
   endtask

   // ------------------------------
   // stimulus helpers.
   // ------------------------------
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge axi4s_in);
         #1;
      end
   endtask

   // holds the beat until in_tready is seen high ahead of an edge.
   task automatic drive_beat(input beat_t w);
      int   waits;
      logic taken;
      waits     = 0;
      taken     = 1'b0;
      in_tdata  = w.tdata;
      in_tkeep  = w.tkeep;
      in_tlast  = w.tlast;
      in_tvalid = 1'b1;
      while (!taken && !aborted) begin
         @(negedge axi4s_in);
         taken = in_tready;
         @(posedge axi4s_in);
         #1;
         waits++;
         if (!taken && waits >= wait_limit) begin
            $display("ERROR: timeout, in_tready stayed low for %0d cycles", waits);
            other_errs++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic send_packet(input int len);
      beat_q_t pkt;
      beat_q_t res;
      beat_t   w;
      int      i;
      int      kbits;
      for (i = 0; i < len; i++) begin
         w.tdata = {$random(seed), $random(seed)};
         kbits   = $random(seed);
         w.tkeep = (i != len - 1) ? 8'hff : ((kbits[7:0] == 8'h00) ? 8'h01 : kbits[7:0]);
         w.tlast = (i == len - 1);
         pkt.push_back(w);
      end
      res = expected_out(pkt, int'(hdr_length));
      foreach (res[j]) exp_out_q.push_back(res[j]);
      res = expected_hdr(pkt, int'(hdr_length));
      foreach (res[j]) exp_hdr_q.push_back(res[j]);
      for (i = 0; i < len; i++) begin
         drive_beat(pkt[i]);
      end
      in_tvalid = 1'b0;
   endtask

   task automatic wait_drained();
      int waits;
      waits = 0;
      while ((exp_out_q.size() != 0 || exp_hdr_q.size() != 0) && !aborted) begin
         @(posedge axi4s_in);
         #1;
         waits++;
         if (waits >= wait_limit) begin
            $display("ERROR: timeout, %0d out beats and %0d hdr_out beats never arrived",
                     exp_out_q.size(), exp_hdr_q.size());
            other_errs++;
            aborted = 1'b1;
         end
      end
      idle_cycles(4);
   endtask

   // the splitter latches the length only while idle.
   task automatic set_length(input split_join_pkg::hdr_len_t len);
      hdr_length = len;
      idle_cycles(4);
   endtask

   // a header packet that no split packet belongs to.
   task automatic inject_orphan();
      beat_q_t pkt;
      beat_t   w;
      int      i;
      for (i = 0; i < 2; i++) begin
         w.tdata = {$random(seed), $random(seed)};
         w.tkeep = 8'hff;
         w.tlast = (i == 1);
         pkt.push_back(w);
      end
      @(negedge axi4s_in);
      foreach (pkt[j]) begin
         ret_q.push_back(pkt[j]);
         exp_out_q.push_back(pkt[j]);
      end
      @(posedge axi4s_in);
      #1;
   endtask

   // ------------------------------
   // ready stalls drawn mid-cycle.
   // ------------------------------
   initial begin : ready_stalls
      int r_out;
      int r_hdr;
      out_tready     = 1'b1;
      hdr_out_tready = 1'b1;
      forever begin
         @(negedge axi4s_in);
         r_out = $random(seed);
         r_hdr = $random(seed);
         @(posedge axi4s_in);
         #1;
         out_tready     = !stall_on || (r_out[1:0] != 2'b00);
         hdr_out_tready = !stall_on || (r_hdr[1:0] != 2'b00);
      end
   end

   // header processor model that returns a header packet once all of it is in.
   initial begin : header_model
      beat_t   w;
      beat_t   exp_w;
      beat_q_t pend_q;
      int      stall_cnt;
      stall_cnt     = 0;
      hdr_in_tdata  = '0;
      hdr_in_tkeep  = '0;
      hdr_in_tlast  = 1'b0;
      hdr_in_tvalid = 1'b0;
      forever begin
         @(negedge axi4s_in);
         if (hdr_in_tvalid && hdr_in_tready) begin
            w         = ret_q.pop_front();
            stall_cnt = 0;
         end else if (hdr_in_tvalid) begin
            stall_cnt++;
            if (stall_cnt == wait_limit) begin
               $display("ERROR: timeout, hdr_in_tready stayed low for %0d cycles", stall_cnt);
               other_errs++;
               aborted = 1'b1;
            end
         end
         if (hdr_out_tvalid && hdr_out_tready) begin
            w.tdata = hdr_out_tdata;
            w.tkeep = hdr_out_tkeep;
            w.tlast = hdr_out_tlast;
            if (exp_hdr_q.size() == 0) begin
               $display("ERROR: beat on hdr_out at %0t with no header word expected", $time);
               other_errs++;
            end else begin
               exp_w = exp_hdr_q.pop_front();
               check_equal(w, exp_w, "hdr_out beat");
            end
            w.tdata = w.tdata ^ hdr_key;
            pend_q.push_back(w);
            if (w.tlast) begin
               foreach (pend_q[j]) ret_q.push_back(pend_q[j]);
               pend_q.delete();
            end
         end
         @(posedge axi4s_in);
         #1;
         if (ret_q.size() != 0) begin
            w             = ret_q[0];
            hdr_in_tdata  = w.tdata;
            hdr_in_tkeep  = w.tkeep;
            hdr_in_tlast  = w.tlast;
            hdr_in_tvalid = 1'b1;
         end else begin
            hdr_in_tvalid = 1'b0;
         end
      end
   end

   // compares every out beat against the expected queue.
   initial begin : out_checker
      beat_t w;
      beat_t exp_w;
      forever begin
         @(negedge axi4s_in);
         if (sop_mismatch) begin
            sop_pulses++;
         end
         if (out_tvalid && out_tready) begin
            w.tdata = out_tdata;
            w.tkeep = out_tkeep;
            w.tlast = out_tlast;
            out_beats++;
            if (exp_out_q.size() == 0) begin
               $display("ERROR: beat on out at %0t with nothing expected", $time);
               other_errs++;
            end else begin
               exp_w = exp_out_q.pop_front();
               check_equal(w, exp_w, "out beat");
            end
         end
      end
   end

   // ------------------------------
   // test sequence.
   // ------------------------------
   initial begin : main_seq
      int n;
      int len;
      rst_n      = 1'b0;
      hdr_length = 8'd2;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = 1'b0;
      in_tvalid  = 1'b0;
      repeat (16) @(posedge axi4s_in);
      #1;
      rst_n = 1'b1;
      idle_cycles(4);

      // two-word header with payload behind it.
      for (len = 3; len <= 10; len++) begin
         send_packet(len);
      end
      wait_drained();

      // packets that end inside the header.
      send_packet(1);
      send_packet(2);
      send_packet(1);
      send_packet(2);
      wait_drained();

      // bypass sends the whole packet through the header processor.
      set_length(8'd0);
      for (len = 1; len <= 6; len++) begin
         send_packet(len);
      end
      wait_drained();

      set_length(8'd2);
      stall_on = 1'b1;
      for (n = 0; n < pkt_count; n++) begin
         len = 1 + ({$random(seed)} % 10);
         send_packet(len);
      end
      wait_drained();
      stall_on = 1'b0;
      idle_cycles(4);
      check_equal(beat_w'(sop_pulses), beat_w'(0), "sop_mismatch pulses before orphan");

      // header with no split packet behind it.
      inject_orphan();
      wait_drained();
      check_equal(beat_w'(sop_pulses), beat_w'(1), "sop_mismatch pulses after orphan");

      $display("summary: %0d value mismatches, %0d other errors, %0d out beats checked",
               mism_errs, other_errs, out_beats);
      if (mism_errs == 0 && other_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
